// ==== upd_periph_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types and constants of the uPD7800 peripheral block
// Register addresses are 4 bits and all data paths are 8 bits wide
// Interrupt index n is also MK bit n and its priority rank
//////////////////////////////////////////////////////////////////////

package upd_periph_pkg;

  // Special register map
  typedef enum logic [3:0] {
    PA     = 4'd0,
    PB     = 4'd1,
    PC     = 4'd2,
    MK     = 4'd3,
    MB     = 4'd4,
    MC     = 4'd5,
    TM0    = 4'd6,
    TM1    = 4'd7,
    IE     = 4'd8,
    INTACK = 4'd9,
    STM    = 4'd10
  } e_spr;

  // Interrupt sources, highest priority first
  typedef enum logic [1:0] {
    INT0 = 2'd0,
    INTT = 2'd1,
    INT1 = 2'd2,
    INT2 = 2'd3
  } e_int_idx;

  localparam int N_INT = 4;

  // Vector addresses returned on acknowledge
  localparam logic [7:0] VEC_INT0 = 8'h04;
  localparam logic [7:0] VEC_INTT = 8'h08;
  localparam logic [7:0] VEC_INT1 = 8'h10;
  localparam logic [7:0] VEC_INT2 = 8'h20;

  localparam logic [7:0] MK_RESET   = 8'hFF;
  localparam logic [7:0] MODE_RESET = 8'hFF;

  typedef struct packed {
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [3:0] paddr;
    logic [7:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [7:0] prdata;
    logic       pready;
  } apb_rsp_t;

  // Write committed at the end of this cycle
  typedef struct packed {
    logic       wr;
    logic [3:0] addr;
    logic [7:0] data;
  } reg_wr_t;

  typedef struct packed {
    logic [7:0] pa_o;
    logic [7:0] pb_o;
    logic [7:0] pb_oe;
    logic [7:0] pc_o;
    logic [7:0] pc_oe;
  } port_pins_t;

endpackage

// ==== upd_apb_regs.sv ====
//////////////////////////////////////////////////////////////////////
// APB slave of the peripheral block, no wait states, no PSLVERR
// MB, MC and STM are write-only and read back as zero
// Timer read-back assumes 8 < TM_WIDTH <= 16
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module upd_apb_regs #(
  parameter int TM_WIDTH = 12
) (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  upd_periph_pkg::apb_req_t apb_req,
  output upd_periph_pkg::apb_rsp_t apb_rsp,
  output upd_periph_pkg::reg_wr_t  wr,
  output logic                     int_ack,
  output logic [7:0]               mk,
  output logic                     ie,
  input  logic [2:0][7:0]          port_rd,
  input  logic [TM_WIDTH-1:0]      tm_rd,
  input  logic [7:0]               vector
);

  logic                 access;
  logic                 rd_access;
  logic [15:0]          tm_ext;
  upd_periph_pkg::e_spr sel;

  //////////////////////////////////////////////////////////////////////
  // Access qualification

  // Access phase is always a single cycle
  assign access    = apb_req.psel & apb_req.penable;
  assign rd_access = access & ~apb_req.pwrite;
  assign sel       = upd_periph_pkg::e_spr'(apb_req.paddr);

  // Write strobe to all units, effect lands on the closing edge
  assign wr.wr   = access & apb_req.pwrite;
  assign wr.addr = apb_req.paddr;
  assign wr.data = apb_req.pwdata;

  // Reading INTACK retires the highest pending source
  assign int_ack = rd_access & (sel == upd_periph_pkg::INTACK);

  assign apb_rsp.pready = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Interrupt mask and enable

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mk <= upd_periph_pkg::MK_RESET;
      ie <= 1'b0;
    end else if (wr.wr) begin
      if (sel == upd_periph_pkg::MK) begin
        mk <= wr.data;
      end
      if (sel == upd_periph_pkg::IE) begin
        ie <= wr.data[0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read data

  // Upper reload bits read with zeros above them
  assign tm_ext = 16'(tm_rd);

  always_comb begin
    case (sel)
      upd_periph_pkg::PA: begin
        apb_rsp.prdata = port_rd[upd_periph_pkg::PA];
      end
      upd_periph_pkg::PB: begin
        apb_rsp.prdata = port_rd[upd_periph_pkg::PB];
      end
      upd_periph_pkg::PC: begin
        apb_rsp.prdata = port_rd[upd_periph_pkg::PC];
      end
      upd_periph_pkg::MK: begin
        apb_rsp.prdata = mk;
      end
      upd_periph_pkg::TM0: begin
        apb_rsp.prdata = tm_ext[7:0];
      end
      upd_periph_pkg::TM1: begin
        apb_rsp.prdata = tm_ext[15:8];
      end
      upd_periph_pkg::IE: begin
        apb_rsp.prdata = {7'b0, ie};
      end
      upd_periph_pkg::INTACK: begin
        apb_rsp.prdata = vector;
      end
      default: begin
        apb_rsp.prdata = 8'h00;
      end
    endcase
  end

endmodule

// ==== upd_int_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// Interrupt unit with INT0 level, INT1/INT2 edge filters and timer
// Edge filters need three high samples after a low one
// INT2 polarity follows MK bit 5, set means rising edge
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module upd_int_ctrl (
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       int0,
  input  logic       int1,
  input  logic       int2,
  input  logic       tm_uf,
  input  logic [7:0] mk,
  input  logic       ie,
  input  logic       int_ack,
  output logic       irq,
  output logic [7:0] vector
);

  logic [3:0]                       shift1;
  logic [3:0]                       shift2;
  logic [upd_periph_pkg::N_INT-1:0] pend;
  logic [upd_periph_pkg::N_INT-1:0] pend_set;
  logic [upd_periph_pkg::N_INT-1:0] pend_clr;
  logic [upd_periph_pkg::N_INT-1:0] active;
  logic [upd_periph_pkg::N_INT-1:0] grant;
  upd_periph_pkg::e_int_idx         top_idx;

  //////////////////////////////////////////////////////////////////////
  // Input sampling

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      shift1 <= 4'b0;
      shift2 <= 4'b0;
    end else begin
      shift1 <= {shift1[2:0], int1};
      shift2 <= {shift2[2:0], int2 ^ ~mk[5]};
    end
  end

  always_comb begin
    pend_set = '0;
    // INT0 is level sensed, re-arms a cycle after an acknowledge
    pend_set[upd_periph_pkg::INT0] = int0 & ~pend[upd_periph_pkg::INT0];
    pend_set[upd_periph_pkg::INTT] = tm_uf;
    pend_set[upd_periph_pkg::INT1] = (shift1 == 4'b0111);
    pend_set[upd_periph_pkg::INT2] = (shift2 == 4'b0111);
  end

  always_comb begin
    pend_clr = '0;
    pend_clr[upd_periph_pkg::INT0] = ~int0;
    if (int_ack) begin
      pend_clr = pend_clr | grant;
    end
  end

  // Pending flags, a new request wins over a clear
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pend <= '0;
    end else begin
      pend <= (pend & ~pend_clr) | pend_set;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Masking and priority

  assign active = pend & ~mk[upd_periph_pkg::N_INT-1:0] & {upd_periph_pkg::N_INT{ie}};
  assign irq    = |active;

  // Lowest index wins
  always_comb begin
    grant   = '0;
    top_idx = upd_periph_pkg::INT0;
    for (int i = upd_periph_pkg::N_INT - 1; i >= 0; i--) begin
      if (active[i]) begin
        grant    = '0;
        grant[i] = 1'b1;
        top_idx  = upd_periph_pkg::e_int_idx'(i);
      end
    end
  end

  always_comb begin
    if (!irq) begin
      vector = 8'h00;
    end else begin
      case (top_idx)
        upd_periph_pkg::INT0: vector = upd_periph_pkg::VEC_INT0;
        upd_periph_pkg::INTT: vector = upd_periph_pkg::VEC_INTT;
        upd_periph_pkg::INT1: vector = upd_periph_pkg::VEC_INT1;
        upd_periph_pkg::INT2: vector = upd_periph_pkg::VEC_INT2;
        default:              vector = 8'h00;
      endcase
    end
  end

endmodule

// ==== upd_timer.sv ====
//////////////////////////////////////////////////////////////////////
// Interval timer, prescaler and down counter in one register
// Underflow period is (reload + 1) << PRESCALE_BITS cycles
// Needs 8 < TM_WIDTH <= 16 and PRESCALE_BITS >= 1
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module upd_timer #(
  parameter int TM_WIDTH      = 12,
  parameter int PRESCALE_BITS = 3
) (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  upd_periph_pkg::reg_wr_t wr,
  output logic [TM_WIDTH-1:0]     tm_rd,
  output logic                    tm_uf
);

  localparam int CW = TM_WIDTH + PRESCALE_BITS;

  logic [TM_WIDTH-1:0] tm_reload;
  logic [15:0]         tm_next;
  logic [CW-1:0]       tc;
  logic                tm_wr;
  logic                stm_wr;

  assign tm_wr  = wr.wr & ((wr.addr == upd_periph_pkg::TM0) | (wr.addr == upd_periph_pkg::TM1));
  assign stm_wr = wr.wr & (wr.addr == upd_periph_pkg::STM);

  // TM0 holds the low byte, TM1 the rest
  always_comb begin
    tm_next = 16'(tm_reload);
    if (wr.addr == upd_periph_pkg::TM0) begin
      tm_next[7:0] = wr.data;
    end else begin
      tm_next[15:8] = wr.data;
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      tm_reload <= '1;
    end else if (tm_wr) begin
      tm_reload <= tm_next[TM_WIDTH-1:0];
    end
  end

  assign tm_rd = tm_reload;
  assign tm_uf = ~|tc;

  // Low bits are the prescaler, restarted on every reload
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      tc <= '1;
    end else if (tm_uf | stm_wr) begin
      tc <= {tm_reload, {PRESCALE_BITS{1'b1}}};
    end else begin
      tc <= tc - 1'b1;
    end
  end

endmodule

// ==== upd_ports.sv ====
//////////////////////////////////////////////////////////////////////
// Parallel ports A, B and C with mode registers MB and MC
// A mode bit of 1 makes the pin an input
// PC bits 6 to 2 always drive, masked by MC where it is set
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module upd_ports (
  input  logic                       CLK,
  input  logic                       rst_n,
  input  upd_periph_pkg::reg_wr_t    wr,
  input  logic [7:0]                 pb_i,
  input  logic [7:0]                 pc_i,
  output upd_periph_pkg::port_pins_t pins,
  output logic [2:0][7:0]            port_rd
);

  logic [7:0] pa;
  logic [7:0] pb;
  logic [7:0] pc;
  logic [7:0] mb;
  logic [7:0] mc;
  logic [7:0] pb_oe;
  logic [7:0] pc_oe;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pa <= 8'h00;
      pb <= 8'h00;
      pc <= 8'h00;
      mb <= upd_periph_pkg::MODE_RESET;
      mc <= upd_periph_pkg::MODE_RESET;
    end else if (wr.wr) begin
      case (upd_periph_pkg::e_spr'(wr.addr))
        upd_periph_pkg::PA: pa <= wr.data;
        upd_periph_pkg::PB: pb <= wr.data;
        upd_periph_pkg::PC: pc <= wr.data;
        upd_periph_pkg::MB: mb <= wr.data;
        upd_periph_pkg::MC: mc <= wr.data;
        default: ;
      endcase
    end
  end

  assign pb_oe = ~mb;
  assign pc_oe = {~mc[7], 5'b11111, ~mc[1:0]};

  assign pins.pa_o  = pa;
  assign pins.pb_o  = pb;
  assign pins.pb_oe = pb_oe;
  assign pins.pc_o  = pc & ~mc;
  assign pins.pc_oe = pc_oe;

  // Driven bits read the register, the others read the pin
  assign port_rd[upd_periph_pkg::PA] = pa;
  assign port_rd[upd_periph_pkg::PB] = (pb & pb_oe) | (pb_i & ~pb_oe);
  assign port_rd[upd_periph_pkg::PC] = (pc & pc_oe) | (pc_i & ~pc_oe);

endmodule

// ==== upd_periph_top.sv ====
//////////////////////////////////////////////////////////////////////
// uPD7800 peripheral block behind an APB slave
// Single clock, writes take effect two cycles after psel rises
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module upd_periph_top #(
  parameter int TM_WIDTH      = 12,
  parameter int PRESCALE_BITS = 3
) (
  input  logic                       CLK,
  input  logic                       rst_n,
  input  upd_periph_pkg::apb_req_t   apb_req,
  output upd_periph_pkg::apb_rsp_t   apb_rsp,
  input  logic                       int0,
  input  logic                       int1,
  input  logic                       int2,
  output logic                       irq,
  input  logic [7:0]                 pb_i,
  input  logic [7:0]                 pc_i,
  output upd_periph_pkg::port_pins_t pins
);

  upd_periph_pkg::reg_wr_t wr;
  logic                    int_ack;
  logic [7:0]              mk;
  logic                    ie;
  logic [2:0][7:0]         port_rd;
  logic [TM_WIDTH-1:0]     tm_rd;
  logic [7:0]              vector;
  logic                    tm_uf;

  upd_apb_regs #(
    .TM_WIDTH(TM_WIDTH)
  ) u_regs (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .apb_req(apb_req),
    .apb_rsp(apb_rsp),
    .wr     (wr),
    .int_ack(int_ack),
    .mk     (mk),
    .ie     (ie),
    .port_rd(port_rd),
    .tm_rd  (tm_rd),
    .vector (vector)
  );

  upd_int_ctrl u_int (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .int0   (int0),
    .int1   (int1),
    .int2   (int2),
    .tm_uf  (tm_uf),
    .mk     (mk),
    .ie     (ie),
    .int_ack(int_ack),
    .irq    (irq),
    .vector (vector)
  );

  upd_timer #(
    .TM_WIDTH     (TM_WIDTH),
    .PRESCALE_BITS(PRESCALE_BITS)
  ) u_timer (
    .CLK  (CLK),
    .rst_n(rst_n),
    .wr   (wr),
    .tm_rd(tm_rd),
    .tm_uf(tm_uf)
  );

  upd_ports u_ports (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .wr     (wr),
    .pb_i   (pb_i),
    .pc_i   (pc_i),
    .pins   (pins),
    .port_rd(port_rd)
  );

endmodule

// ==== tb_upd_periph_assert.sv ====
//////////////////////////////////////////////////////////////////////
// Bus and interrupt properties bound into upd_periph_top
// Sampled on the rising CLK edge, off while rst_n is low
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_upd_periph_assert (
  input logic                     CLK,
  input logic                     rst_n,
  input upd_periph_pkg::apb_req_t apb_req,
  input upd_periph_pkg::apb_rsp_t apb_rsp,
  input logic                     irq,
  input logic                     ie,
  input logic                     tm_uf
);

  int n_fail = 0;

  // No wait states on any access phase
  pready_in_access: assert property (@(posedge CLK) disable iff (!rst_n)
    (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
    else begin
      n_fail++;
      $error("pready low during an APB access phase");
    end

  irq_needs_ie: assert property (@(posedge CLK) disable iff (!rst_n) !ie |-> !irq)
    else begin
      n_fail++;
      $error("irq high while interrupts are disabled");
    end

  // Reload is at least 7, so underflows are never adjacent
  uf_single_pulse: assert property (@(posedge CLK) disable iff (!rst_n) tm_uf |=> !tm_uf)
    else begin
      n_fail++;
      $error("timer underflow pulse lasted two cycles");
    end

endmodule

bind upd_periph_top tb_upd_periph_assert chk (
  .CLK    (CLK),
  .rst_n  (rst_n),
  .apb_req(apb_req),
  .apb_rsp(apb_rsp),
  .irq    (irq),
  .ie     (ie),
  .tm_uf  (tm_uf)
);

// ==== tb_upd_periph.sv ====
//////////////////////////////////////////////////////////////////////
// Table-driven testbench for the uPD7800 peripheral block
// The table is built at time zero, then applied one step at a time
// Port data and pin levels come from a 16-bit LFSR, seed 62
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_upd_periph;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_IN, OP_WAIT, OP_IRQ, OP_PINS} op_e;

  // One table entry, exp holds a read value or the full pin vector
  typedef struct packed {
    op_e         op;
    logic [3:0]  addr;
    logic [7:0]  data;
    logic [2:0]  ints;
    logic [7:0]  pbi;
    logic [7:0]  pci;
    logic [39:0] exp;
  } step_t;

  logic                       CLK;
  logic                       rst_n;
  upd_periph_pkg::apb_req_t   apb_req;
  upd_periph_pkg::apb_rsp_t   apb_rsp;
  logic                       int0;
  logic                       int1;
  logic                       int2;
  logic                       irq;
  logic [7:0]                 pb_i;
  logic [7:0]                 pc_i;
  upd_periph_pkg::port_pins_t pins;

  step_t       steps[$];
  logic [15:0] lfsr = 16'd62;
  int          n_chk = 0;
  int          n_err = 0;
  bit          built = 1'b0;

  upd_periph_top #(.TM_WIDTH(12), .PRESCALE_BITS(3)) dut (.*);

  always #20 CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Random data and reference rules

  // Taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++) begin
      b = {b[6:0], lfsr_bit()};
    end
    return b;
  endfunction

  // Driven bits read the register, the others the pin
  function automatic logic [7:0] pin_mix(input logic [7:0] r, input logic [7:0] p,
                                         input logic [7:0] oe);
    return (r & oe) | (p & ~oe);
  endfunction

  function automatic logic [7:0] pc_dir(input logic [7:0] mc);
    return {~mc[7], 5'b11111, ~mc[1:0]};
  endfunction

  task automatic push(input op_e op, input logic [3:0] addr, input logic [7:0] data,
                      input logic [2:0] ints, input logic [7:0] pbi, input logic [7:0] pci,
                      input logic [39:0] exp);
    steps.push_back(step_t'{op, addr, data, ints, pbi, pci, exp});
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus and pin drivers

  task automatic next_cycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [7:0] data);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    next_cycle();
    apb_req.penable = 1'b1;
    next_cycle();
    apb_req = '0;
  endtask

  // Read data sampled mid-cycle of the access phase
  task automatic apb_read(input logic [3:0] addr, output logic [7:0] data);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 8'h00};
    next_cycle();
    apb_req.penable = 1'b1;
    @(negedge CLK);
    data = apb_rsp.prdata;
    next_cycle();
    apb_req = '0;
  endtask

  task automatic compare(input string name, input logic [39:0] exp, input logic [39:0] got);
    n_chk++;
    assert (got === exp) else begin
      n_err++;
      $display("ERR %s: expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic run_step(input step_t s);
    logic [7:0] rdata;
    case (s.op)
      OP_WR: apb_write(s.addr, s.data);
      OP_RD: begin
        apb_read(s.addr, rdata);
        compare($sformatf("prdata at %h", s.addr), 40'(s.exp[7:0]), 40'(rdata));
      end
      OP_IN: begin
        next_cycle();
        {int2, int1, int0} = s.ints;
        pb_i = s.pbi;
        pc_i = s.pci;
      end
      OP_WAIT: repeat (s.data) next_cycle();
      OP_IRQ: compare("irq", 40'(s.exp[0]), 40'(irq));
      OP_PINS: compare("pins", s.exp, pins);
      default: ;
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table

  task automatic build_table();
    logic [7:0] mb;
    logic [7:0] mc;
    logic [7:0] pa;
    logic [7:0] pb;
    logic [7:0] pc;
    logic [7:0] pbi;
    logic [7:0] pci;
    logic [7:0] r;
    // Ports, two rounds of random modes, data and pins
    for (int i = 0; i < 2; i++) begin
      mb  = rand_byte();
      mc  = rand_byte();
      pa  = rand_byte();
      pb  = rand_byte();
      pc  = rand_byte();
      pbi = rand_byte();
      pci = rand_byte();
      push(OP_WR, upd_periph_pkg::MB, mb, '0, '0, '0, '0);
      push(OP_WR, upd_periph_pkg::MC, mc, '0, '0, '0, '0);
      push(OP_WR, upd_periph_pkg::PA, pa, '0, '0, '0, '0);
      push(OP_WR, upd_periph_pkg::PB, pb, '0, '0, '0, '0);
      push(OP_WR, upd_periph_pkg::PC, pc, '0, '0, '0, '0);
      push(OP_IN, '0, '0, 3'b000, pbi, pci, '0);
      push(OP_RD, upd_periph_pkg::PA, '0, '0, '0, '0, 40'(pa));
      push(OP_RD, upd_periph_pkg::PB, '0, '0, '0, '0, 40'(pin_mix(pb, pbi, ~mb)));
      push(OP_RD, upd_periph_pkg::PC, '0, '0, '0, '0, 40'(pin_mix(pc, pci, pc_dir(mc))));
      push(OP_PINS, '0, '0, '0, '0, '0, {pa, pb, ~mb, pc & ~mc, pc_dir(mc)});
    end
    // Reset mask and enable, then INT0 over INT1
    push(OP_RD, upd_periph_pkg::MK, '0, '0, '0, '0, 40'hFF);
    push(OP_RD, upd_periph_pkg::IE, '0, '0, '0, '0, 40'h00);
    push(OP_IN, '0, '0, 3'b001, '0, '0, '0);
    push(OP_WAIT, '0, 8'd4, '0, '0, '0, '0);
    push(OP_IRQ, '0, '0, '0, '0, '0, 40'h0);
    push(OP_WR, upd_periph_pkg::IE, 8'h01, '0, '0, '0, '0);
    push(OP_WR, upd_periph_pkg::MK, 8'hFA, '0, '0, '0, '0);
    push(OP_IN, '0, '0, 3'b011, '0, '0, '0);
    push(OP_WAIT, '0, 8'd5, '0, '0, '0, '0);
    push(OP_IRQ, '0, '0, '0, '0, '0, 40'h1);
    push(OP_RD, upd_periph_pkg::INTACK, '0, '0, '0, '0, 40'h04);
    push(OP_IN, '0, '0, 3'b010, '0, '0, '0);
    push(OP_WAIT, '0, 8'd3, '0, '0, '0, '0);
    push(OP_RD, upd_periph_pkg::INTACK, '0, '0, '0, '0, 40'h10);
    push(OP_IRQ, '0, '0, '0, '0, '0, 40'h0);
    push(OP_IN, '0, '0, 3'b000, '0, '0, '0);
    // INT1 filter, 2-cycle pulse dropped, 3-cycle pulse taken
    push(OP_WR, upd_periph_pkg::MK, 8'hFB, '0, '0, '0, '0);
    push(OP_IN, '0, '0, 3'b010, '0, '0, '0);
    push(OP_WAIT, '0, 8'd1, '0, '0, '0, '0);
    push(OP_IN, '0, '0, 3'b000, '0, '0, '0);
    push(OP_WAIT, '0, 8'd4, '0, '0, '0, '0);
    push(OP_RD, upd_periph_pkg::INTACK, '0, '0, '0, '0, 40'h00);
    push(OP_IN, '0, '0, 3'b010, '0, '0, '0);
    push(OP_WAIT, '0, 8'd2, '0, '0, '0, '0);
    push(OP_IN, '0, '0, 3'b000, '0, '0, '0);
    push(OP_WAIT, '0, 8'd4, '0, '0, '0, '0);
    push(OP_RD, upd_periph_pkg::INTACK, '0, '0, '0, '0, 40'h10);
    // INT2 rising edge with MK[5] set, falling edge with it clear
    push(OP_WR, upd_periph_pkg::MK, 8'hF7, '0, '0, '0, '0);
    push(OP_IN, '0, '0, 3'b100, '0, '0, '0);
    push(OP_WAIT, '0, 8'd5, '0, '0, '0, '0);
    push(OP_RD, upd_periph_pkg::INTACK, '0, '0, '0, '0, 40'h20);
    push(OP_WR, upd_periph_pkg::MK, 8'hD7, '0, '0, '0, '0);
    push(OP_IN, '0, '0, 3'b000, '0, '0, '0);
    push(OP_WAIT, '0, 8'd5, '0, '0, '0, '0);
    push(OP_RD, upd_periph_pkg::INTACK, '0, '0, '0, '0, 40'h20);
    push(OP_IN, '0, '0, 3'b100, '0, '0, '0);
    push(OP_WAIT, '0, 8'd5, '0, '0, '0, '0);
    push(OP_RD, upd_periph_pkg::INTACK, '0, '0, '0, '0, 40'h00);
    // Timer with reload 3, underflow every 32 cycles after STM
    push(OP_WR, upd_periph_pkg::MK, 8'hFD, '0, '0, '0, '0);
    push(OP_WR, upd_periph_pkg::TM0, 8'h03, '0, '0, '0, '0);
    push(OP_WR, upd_periph_pkg::TM1, 8'h00, '0, '0, '0, '0);
    push(OP_WR, upd_periph_pkg::STM, 8'h00, '0, '0, '0, '0);
    push(OP_WAIT, '0, 8'd28, '0, '0, '0, '0);
    push(OP_RD, upd_periph_pkg::INTACK, '0, '0, '0, '0, 40'h00);
    push(OP_WAIT, '0, 8'd9, '0, '0, '0, '0);
    push(OP_RD, upd_periph_pkg::INTACK, '0, '0, '0, '0, 40'h08);
    push(OP_WAIT, '0, 8'd17, '0, '0, '0, '0);
    push(OP_RD, upd_periph_pkg::INTACK, '0, '0, '0, '0, 40'h00);
    push(OP_WAIT, '0, 8'd8, '0, '0, '0, '0);
    push(OP_RD, upd_periph_pkg::INTACK, '0, '0, '0, '0, 40'h08);
    push(OP_IRQ, '0, '0, '0, '0, '0, 40'h0);
    r = rand_byte();
    push(OP_WR, upd_periph_pkg::TM1, r, '0, '0, '0, '0);
    push(OP_RD, upd_periph_pkg::TM1, '0, '0, '0, '0, 40'({4'h0, r[3:0]}));
    push(OP_RD, upd_periph_pkg::TM0, '0, '0, '0, '0, 40'h03);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin
    CLK     = 1'b0;
    rst_n   = 1'b0;
    apb_req = '0;
    int0    = 1'b0;
    int1    = 1'b0;
    int2    = 1'b0;
    pb_i    = 8'h00;
    pc_i    = 8'h00;
    build_table();
    built = 1'b1;
    repeat (2) @(posedge CLK);
    #2;
    rst_n = 1'b1;
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             n_chk, n_err, dut.chk.n_fail);
    if (n_err == 0 && dut.chk.n_fail == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    wait (built);
    repeat (steps.size() * 10 + 5000) @(posedge CLK);
    $display("Timeout: the stimulus table did not complete in time");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== flist.f ====
upd_periph_pkg.sv
upd_apb_regs.sv
upd_int_ctrl.sv
upd_timer.sv
upd_ports.sv
upd_periph_top.sv
tb_upd_periph_assert.sv
tb_upd_periph.sv

// ==== Makefile ====
# Verilator flow for the uPD7800 peripheral block
VERILATOR ?= verilator
TOP       ?= tb_upd_periph
RTL_TOP   ?= upd_periph_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIMFLAGS  ?= +verilator+error+limit+100

SRCS     := $(shell cat $(FLIST))
RTL_SRCS := $(filter-out tb_%,$(SRCS))
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint clean

all: $(SIM_BIN)
	./$(SIM_BIN) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@grep -qx "RESULT: PASS" $(LOG)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
